// File: design/core_cfg_pkg.sv
package core_cfg_pkg;

  // RV32E datapath sizing
  localparam int xlen = 32;
  localparam int reg_cnt = 16;

  // data and address words
  typedef logic [xlen-1:0] word_t;

  // raw instruction word as fetched
  typedef logic [31:0] inst_t;

  // RV32E register index, upper bit of the ISA field is dropped
  typedef logic [3:0] reg_idx_t;

  // funct3 plus one funct7 bit
  typedef logic [3:0] alu_op_t;

  // decode stage control
  typedef enum logic [0:0] {
    dec_idle,
    dec_hold
  } dec_state_e;

endpackage

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [6:0] opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_auipc = 7'b0010111;
  localparam opcode_t op_jal = 7'b1101111;
  localparam opcode_t op_jalr = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load = 7'b0000011;
  localparam opcode_t op_store = 7'b0100011;
  localparam opcode_t op_imm = 7'b0010011;
  localparam opcode_t op_reg = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

  // funct3 values
  localparam logic [2:0] funct3_zero = 3'b000;
  // srl/sra share this, funct7 picks between them
  localparam logic [2:0] funct3_sr = 3'b101;

  // csr access forms under the system opcode
  localparam logic [2:0] funct3_csrrw = 3'b001;
  localparam logic [2:0] funct3_csrrs = 3'b010;
  localparam logic [2:0] funct3_csrrc = 3'b011;
  localparam logic [2:0] funct3_csrrwi = 3'b101;
  localparam logic [2:0] funct3_csrrsi = 3'b110;
  localparam logic [2:0] funct3_csrrci = 3'b111;

  // imm[11:0] of the privileged system instructions
  localparam logic [11:0] sys_ecall = 12'h000;
  localparam logic [11:0] sys_ebreak = 12'h001;
  localparam logic [11:0] sys_mret = 12'h302;

  // alu operation is {funct7[5], funct3}
  localparam logic [3:0] alu_add = 4'b0000;
  localparam int alu_sub_bit = 3;

endpackage

// File: design/system_decoder.sv
`timescale 1ns/10ps

module system_decoder (
  input  core_cfg_pkg::inst_t inst_i,
  output logic                system_o,
  output logic                system_func3_zero_o,
  output logic                csr_wen_o,
  output logic                ebreak_o
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [11:0]         sys_imm;
  logic                priv_form;
  logic                is_ecall;
  logic                is_mret;
  logic                csr_rmw;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign sys_imm = inst_i[31:20];

  assign system_o = (opcode == rv_isa_pkg::op_system);

  // ecall, ebreak and mret all live under funct3 zero
  assign priv_form = system_o && (funct3 == rv_isa_pkg::funct3_zero);
  assign is_ecall = priv_form && (sys_imm == rv_isa_pkg::sys_ecall);
  assign is_mret = priv_form && (sys_imm == rv_isa_pkg::sys_mret);
  assign ebreak_o = priv_form && (sys_imm == rv_isa_pkg::sys_ebreak);

  assign system_func3_zero_o = is_ecall || ebreak_o || is_mret;

  assign csr_rmw = system_o && ((funct3 == rv_isa_pkg::funct3_csrrw) ||
                                (funct3 == rv_isa_pkg::funct3_csrrs) ||
                                (funct3 == rv_isa_pkg::funct3_csrrc) ||
                                (funct3 == rv_isa_pkg::funct3_csrrwi) ||
                                (funct3 == rv_isa_pkg::funct3_csrrsi) ||
                                (funct3 == rv_isa_pkg::funct3_csrrci));

  // ecall updates mepc, mret updates mstatus
  assign csr_wen_o = csr_rmw || is_ecall || is_mret;

endmodule

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  core_cfg_pkg::reg_idx_t raddr1_i,
  input  core_cfg_pkg::reg_idx_t raddr2_i,
  input  logic                   wen_i,
  input  core_cfg_pkg::reg_idx_t waddr_i,
  input  core_cfg_pkg::word_t    wdata_i,
  output core_cfg_pkg::word_t    rdata1_o,
  output core_cfg_pkg::word_t    rdata2_o
);

  core_cfg_pkg::word_t regs [core_cfg_pkg::reg_cnt];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_cfg_pkg::reg_cnt; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // no write bypass, a pending write shows up as busy instead
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// File: design/busy_table.sv
`timescale 1ns/10ps

module busy_table (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   set_i,
  input  core_cfg_pkg::reg_idx_t set_idx_i,
  input  logic                   clr_i,
  input  core_cfg_pkg::reg_idx_t clr_idx_i,
  input  core_cfg_pkg::reg_idx_t q1_idx_i,
  input  core_cfg_pkg::reg_idx_t q2_idx_i,
  output logic                   q1_busy_o,
  output logic                   q2_busy_o
);

  logic [core_cfg_pkg::reg_cnt-1:0] busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (clr_i) begin
        busy_q[clr_idx_i] <= 1'b0;
      end
      // placed after the clear so a same-cycle set on the same index wins
      if (set_i && (set_idx_i != '0)) begin
        busy_q[set_idx_i] <= 1'b1;
      end
    end
  end

  assign q1_busy_o = busy_q[q1_idx_i];
  assign q2_busy_o = busy_q[q2_idx_i];

  // every writeback must match an earlier issue
  clr_needs_busy: assert property (
    @(posedge clk) disable iff (rst)
    (clr_i && (clr_idx_i != '0)) |-> busy_q[clr_idx_i]
  ) else $error("writeback to x%0d without a pending write", clr_idx_i);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  core_cfg_pkg::inst_t     inst_i,
  input  core_cfg_pkg::word_t     pc_i,
  input  logic                    spec_i,
  input  logic                    prev_valid_i,
  input  logic                    next_ready_i,
  input  core_cfg_pkg::word_t     rdata1_i,
  input  core_cfg_pkg::word_t     rdata2_i,
  input  logic                    busy1_i,
  input  logic                    busy2_i,
  input  logic                    exu_valid_i,
  input  core_cfg_pkg::reg_idx_t  exu_rd_i,
  input  core_cfg_pkg::word_t     exu_data_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output core_cfg_pkg::reg_idx_t  rs1_o,
  output core_cfg_pkg::reg_idx_t  rs2_o,
  output core_cfg_pkg::reg_idx_t  rd_o,
  output rv_isa_pkg::opcode_t     opcode_o,
  output core_cfg_pkg::alu_op_t   alu_op_o,
  output core_cfg_pkg::word_t     op1_o,
  output core_cfg_pkg::word_t     op2_o,
  output core_cfg_pkg::word_t     imm_o,
  output core_cfg_pkg::word_t     op_j_o,
  output core_cfg_pkg::word_t     rwaddr_o,
  output logic                    en_j_o,
  output logic                    ren_o,
  output logic                    wen_o,
  output logic                    illegal_o,
  output logic                    system_o,
  output logic                    system_func3_zero_o,
  output logic                    csr_wen_o,
  output logic                    ebreak_o,
  output core_cfg_pkg::word_t     pc_o,
  output core_cfg_pkg::inst_t     inst_o,
  output logic                    spec_o,
  output logic                    issue_o,
  output core_cfg_pkg::reg_idx_t  issue_rd_o
);

  core_cfg_pkg::dec_state_e state_q;
  logic                     valid_q;
  core_cfg_pkg::inst_t      inst_q;
  core_cfg_pkg::word_t      pc_q;
  logic                     spec_q;

  logic [2:0]             funct3;
  core_cfg_pkg::reg_idx_t rd;
  core_cfg_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                   fwd1, fwd2;
  core_cfg_pkg::word_t    src1, src2;
  logic                   reads_src, hazard;
  logic                   accept, transfer;
  logic                   writes_rd, is_mem, known;

  // field extraction, RV32E keeps only four index bits
  assign opcode_o = inst_q[6:0];
  assign rs1_o = inst_q[18:15];
  assign rs2_o = inst_q[23:20];
  assign rd = inst_q[10:7];
  assign funct3 = inst_q[14:12];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // execute-stage forward, x0 never takes it
  assign fwd1 = exu_valid_i && (exu_rd_i == rs1_o) && (rs1_o != '0);
  assign fwd2 = exu_valid_i && (exu_rd_i == rs2_o) && (rs2_o != '0);
  assign src1 = fwd1 ? exu_data_i : rdata1_i;
  assign src2 = fwd2 ? exu_data_i : rdata2_i;

  assign reads_src = (opcode_o != rv_isa_pkg::op_lui) &&
                     (opcode_o != rv_isa_pkg::op_auipc) &&
                     (opcode_o != rv_isa_pkg::op_jal);
  assign hazard = valid_q && reads_src && ((busy1_i && !fwd1) || (busy2_i && !fwd2));

  // handshake
  assign valid_o = valid_q && !hazard;
  assign ready_o = (state_q == core_cfg_pkg::dec_idle) && !hazard && next_ready_i;
  assign accept = prev_valid_i && ready_o;
  assign transfer = valid_o && next_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= core_cfg_pkg::dec_idle;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        core_cfg_pkg::dec_idle: begin
          if (accept) begin
            valid_q <= 1'b1;
          end else if (transfer) begin
            valid_q <= 1'b0;
          end
          if (valid_o && !next_ready_i) begin
            state_q <= core_cfg_pkg::dec_hold;
          end
        end
        core_cfg_pkg::dec_hold: begin
          // release costs one bubble since ready_o stays low here
          if (next_ready_i) begin
            state_q <= core_cfg_pkg::dec_idle;
            if (transfer) begin
              valid_q <= 1'b0;
            end
          end
        end
        default: state_q <= core_cfg_pkg::dec_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q <= pc_i;
      spec_q <= spec_i;
    end
  end

  assign pc_o = pc_q;
  assign inst_o = inst_q;
  assign spec_o = spec_q;

  // operand and alu selection
  always_comb begin
    op1_o = '0;
    op2_o = '0;
    imm_o = '0;
    alu_op_o = rv_isa_pkg::alu_add;
    known = 1'b1;
    case (opcode_o)
      rv_isa_pkg::op_lui: begin
        imm_o = imm_u;
        op2_o = imm_u;
      end
      rv_isa_pkg::op_auipc: begin
        imm_o = imm_u;
        op1_o = pc_q;
        op2_o = imm_u;
      end
      rv_isa_pkg::op_jal: begin
        imm_o = imm_j;
        op1_o = pc_q;
        op2_o = core_cfg_pkg::word_t'(4);
      end
      rv_isa_pkg::op_jalr: begin
        imm_o = imm_i;
        op1_o = pc_q;
        op2_o = core_cfg_pkg::word_t'(4);
      end
      rv_isa_pkg::op_branch: begin
        imm_o = imm_b;
        op1_o = src1;
        op2_o = src2;
        alu_op_o = {1'b0, funct3};
      end
      rv_isa_pkg::op_load: begin
        imm_o = imm_i;
        op1_o = src1;
        op2_o = imm_i;
        alu_op_o = {1'b0, funct3};
      end
      rv_isa_pkg::op_store: begin
        imm_o = imm_s;
        op1_o = src1;
        op2_o = src2;
        alu_op_o = {1'b0, funct3};
      end
      rv_isa_pkg::op_imm: begin
        imm_o = imm_i;
        op1_o = src1;
        op2_o = imm_i;
        alu_op_o = {1'b0, funct3};
        // srai differs from srli only in funct7[5]
        if (funct3 == rv_isa_pkg::funct3_sr) begin
          alu_op_o[rv_isa_pkg::alu_sub_bit] = inst_q[30];
        end
      end
      rv_isa_pkg::op_reg: begin
        op1_o = src1;
        op2_o = src2;
        alu_op_o = {1'b0, funct3};
        alu_op_o[rv_isa_pkg::alu_sub_bit] = inst_q[30];
      end
      rv_isa_pkg::op_system: begin
        imm_o = imm_i;
        op1_o = src1;
        alu_op_o = {1'b0, funct3};
      end
      default: known = 1'b0;
    endcase
  end

  assign writes_rd = (opcode_o == rv_isa_pkg::op_lui) || (opcode_o == rv_isa_pkg::op_auipc) ||
                     (opcode_o == rv_isa_pkg::op_jal) || (opcode_o == rv_isa_pkg::op_jalr) ||
                     (opcode_o == rv_isa_pkg::op_load) || (opcode_o == rv_isa_pkg::op_imm) ||
                     (opcode_o == rv_isa_pkg::op_reg) || (opcode_o == rv_isa_pkg::op_system);
  assign rd_o = writes_rd ? rd : '0;

  assign ren_o = (opcode_o == rv_isa_pkg::op_load);
  assign wen_o = (opcode_o == rv_isa_pkg::op_store);
  assign is_mem = ren_o || wen_o;
  assign en_j_o = (opcode_o == rv_isa_pkg::op_jal) || (opcode_o == rv_isa_pkg::op_jalr) ||
                  (opcode_o == rv_isa_pkg::op_branch) || (opcode_o == rv_isa_pkg::op_system);

  // jump base, pc-relative or register-relative
  always_comb begin
    op_j_o = '0;
    if ((opcode_o == rv_isa_pkg::op_jal) || (opcode_o == rv_isa_pkg::op_branch)) begin
      op_j_o = pc_q;
    end else if ((opcode_o == rv_isa_pkg::op_jalr) || is_mem) begin
      op_j_o = src1;
    end
  end

  assign rwaddr_o = is_mem ? (src1 + imm_o) : '0;
  assign illegal_o = valid_q && !known;

  // busy table marks rd pending once execute takes the instruction
  assign issue_o = transfer && (rd_o != '0);
  assign issue_rd_o = rd_o;

  system_decoder u_system_decoder (
    .inst_i              (inst_q),
    .system_o            (system_o),
    .system_func3_zero_o (system_func3_zero_o),
    .csr_wen_o           (csr_wen_o),
    .ebreak_o            (ebreak_o)
  );

  // a held instruction must not change or vanish under back-pressure
  hold_while_stalled: assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> (valid_o && $stable(inst_o) && $stable(pc_o))
  ) else $error("decode output changed while next stage was stalled");

endmodule

// File: design/decode_top.sv
`timescale 1ns/10ps

module decode_top (
  input  logic                   clk,
  input  logic                   rst,
  // fetch side
  input  core_cfg_pkg::inst_t    inst_i,
  input  core_cfg_pkg::word_t    pc_i,
  input  logic                   spec_i,
  input  logic                   prev_valid_i,
  input  logic                   next_ready_i,
  // execute forward
  input  logic                   exu_valid_i,
  input  core_cfg_pkg::reg_idx_t exu_rd_i,
  input  core_cfg_pkg::word_t    exu_data_i,
  // writeback
  input  logic                   wb_en_i,
  input  core_cfg_pkg::reg_idx_t wb_rd_i,
  input  core_cfg_pkg::word_t    wb_data_i,
  // decoded instruction to execute
  output logic                   ready_o,
  output logic                   valid_o,
  output core_cfg_pkg::reg_idx_t rs1_o,
  output core_cfg_pkg::reg_idx_t rs2_o,
  output core_cfg_pkg::reg_idx_t rd_o,
  output rv_isa_pkg::opcode_t    opcode_o,
  output core_cfg_pkg::alu_op_t  alu_op_o,
  output core_cfg_pkg::word_t    op1_o,
  output core_cfg_pkg::word_t    op2_o,
  output core_cfg_pkg::word_t    imm_o,
  output core_cfg_pkg::word_t    op_j_o,
  output core_cfg_pkg::word_t    rwaddr_o,
  output logic                   en_j_o,
  output logic                   ren_o,
  output logic                   wen_o,
  output logic                   illegal_o,
  output logic                   system_o,
  output logic                   system_func3_zero_o,
  output logic                   csr_wen_o,
  output logic                   ebreak_o,
  output core_cfg_pkg::word_t    pc_o,
  output core_cfg_pkg::inst_t    inst_o,
  output logic                   spec_o
);

  core_cfg_pkg::word_t    rdata1, rdata2;
  logic                   busy1, busy2;
  logic                   issue;
  core_cfg_pkg::reg_idx_t issue_rd;

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1_o),
    .raddr2_i (rs2_o),
    .wen_i    (wb_en_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  busy_table u_busy_table (
    .clk       (clk),
    .rst       (rst),
    .set_i     (issue),
    .set_idx_i (issue_rd),
    .clr_i     (wb_en_i),
    .clr_idx_i (wb_rd_i),
    .q1_idx_i  (rs1_o),
    .q2_idx_i  (rs2_o),
    .q1_busy_o (busy1),
    .q2_busy_o (busy2)
  );

  decode_stage u_decode_stage (
    .clk                 (clk),
    .rst                 (rst),
    .inst_i              (inst_i),
    .pc_i                (pc_i),
    .spec_i              (spec_i),
    .prev_valid_i        (prev_valid_i),
    .next_ready_i        (next_ready_i),
    .rdata1_i            (rdata1),
    .rdata2_i            (rdata2),
    .busy1_i             (busy1),
    .busy2_i             (busy2),
    .exu_valid_i         (exu_valid_i),
    .exu_rd_i            (exu_rd_i),
    .exu_data_i          (exu_data_i),
    .ready_o             (ready_o),
    .valid_o             (valid_o),
    .rs1_o               (rs1_o),
    .rs2_o               (rs2_o),
    .rd_o                (rd_o),
    .opcode_o            (opcode_o),
    .alu_op_o            (alu_op_o),
    .op1_o               (op1_o),
    .op2_o               (op2_o),
    .imm_o               (imm_o),
    .op_j_o              (op_j_o),
    .rwaddr_o            (rwaddr_o),
    .en_j_o              (en_j_o),
    .ren_o               (ren_o),
    .wen_o               (wen_o),
    .illegal_o           (illegal_o),
    .system_o            (system_o),
    .system_func3_zero_o (system_func3_zero_o),
    .csr_wen_o           (csr_wen_o),
    .ebreak_o            (ebreak_o),
    .pc_o                (pc_o),
    .inst_o              (inst_o),
    .spec_o              (spec_o),
    .issue_o             (issue),
    .issue_rd_o          (issue_rd)
  );

endmodule

// File: bench/decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

  logic clk = 1'b0;
  logic rst = 1'b1;
  core_cfg_pkg::inst_t inst_i = '0;
  core_cfg_pkg::word_t pc_i = '0;
  logic spec_i = 1'b0;
  logic prev_valid_i = 1'b0;
  logic next_ready_i = 1'b1;
  logic exu_valid_i = 1'b0;
  core_cfg_pkg::reg_idx_t exu_rd_i = '0;
  core_cfg_pkg::word_t exu_data_i = '0;
  logic wb_en_i = 1'b0;
  core_cfg_pkg::reg_idx_t wb_rd_i = '0;
  core_cfg_pkg::word_t wb_data_i = '0;

  logic ready_o, valid_o, en_j_o, ren_o, wen_o, illegal_o;
  logic system_o, system_func3_zero_o, csr_wen_o, ebreak_o, spec_o;
  core_cfg_pkg::reg_idx_t rs1_o, rs2_o, rd_o;
  rv_isa_pkg::opcode_t opcode_o;
  core_cfg_pkg::alu_op_t alu_op_o;
  core_cfg_pkg::word_t op1_o, op2_o, imm_o, op_j_o, rwaddr_o, pc_o;
  core_cfg_pkg::inst_t inst_o;

  integer seed = 99189;
  integer errors = 0;
  integer accepts = 0;
  integer transfers = 0;
  logic expect_stall = 1'b0;
  core_cfg_pkg::word_t shadow [core_cfg_pkg::reg_cnt];
  core_cfg_pkg::reg_idx_t pending [$];
  core_cfg_pkg::inst_t exp_inst = '0;
  core_cfg_pkg::word_t exp_pc = '0;
  logic exp_spec = 1'b0;

  // expected values from the reference decode
  core_cfg_pkg::word_t e_op1, e_op2, e_imm, e_opj, e_rwaddr, s1, s2;
  core_cfg_pkg::word_t ii, is, ib, iu, ij;
  core_cfg_pkg::alu_op_t e_alu;
  core_cfg_pkg::reg_idx_t e_rd;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [3:0] e_ctrl;
  logic [3:0] e_sys;
  logic known, ecall, mret;

  decode_top dut0 (.*);

  always #20 clk = ~clk;

  always_comb begin
    opc = exp_inst[6:0];
    f3 = exp_inst[14:12];
    ii = {{20{exp_inst[31]}}, exp_inst[31:20]};
    is = {{20{exp_inst[31]}}, exp_inst[31:25], exp_inst[11:7]};
    ib = {{20{exp_inst[31]}}, exp_inst[7], exp_inst[30:25], exp_inst[11:8], 1'b0};
    iu = {exp_inst[31:12], 12'h000};
    ij = {{12{exp_inst[31]}}, exp_inst[19:12], exp_inst[20], exp_inst[30:21], 1'b0};
    s1 = (exu_valid_i && exu_rd_i == exp_inst[18:15] && exp_inst[18:15] != 0) ?
         exu_data_i : shadow[exp_inst[18:15]];
    s2 = (exu_valid_i && exu_rd_i == exp_inst[23:20] && exp_inst[23:20] != 0) ?
         exu_data_i : shadow[exp_inst[23:20]];
    e_op1 = '0;
    e_op2 = '0;
    e_imm = '0;
    e_alu = 4'd0;
    known = 1'b1;
    case (opc)
      7'b0110111: begin e_op2 = iu; e_imm = iu; end
      7'b0010111: begin e_op1 = exp_pc; e_op2 = iu; e_imm = iu; end
      7'b1101111: begin e_op1 = exp_pc; e_op2 = 4; e_imm = ij; end
      7'b1100111: begin e_op1 = exp_pc; e_op2 = 4; e_imm = ii; end
      7'b1100011: begin e_op1 = s1; e_op2 = s2; e_imm = ib; e_alu = {1'b0, f3}; end
      7'b0000011: begin e_op1 = s1; e_op2 = ii; e_imm = ii; e_alu = {1'b0, f3}; end
      7'b0100011: begin e_op1 = s1; e_op2 = s2; e_imm = is; e_alu = {1'b0, f3}; end
      7'b0010011: begin
        e_op1 = s1;
        e_op2 = ii;
        e_imm = ii;
        e_alu = {(f3 == 3'd5) && exp_inst[30], f3};
      end
      7'b0110011: begin e_op1 = s1; e_op2 = s2; e_alu = {exp_inst[30], f3}; end
      7'b1110011: begin e_op1 = s1; e_imm = ii; e_alu = {1'b0, f3}; end
      default: known = 1'b0;
    endcase
    e_rd = (known && opc != 7'b1100011 && opc != 7'b0100011) ? exp_inst[10:7] : 4'd0;
    e_opj = (opc == 7'b1101111 || opc == 7'b1100011) ? exp_pc :
            (opc == 7'b1100111 || opc == 7'b0000011 || opc == 7'b0100011) ? s1 : '0;
    e_rwaddr = (opc == 7'b0000011 || opc == 7'b0100011) ? s1 + e_imm : '0;
    // jump, load, store, illegal
    e_ctrl = {opc == 7'b1101111 || opc == 7'b1100111 || opc == 7'b1100011 ||
              opc == 7'b1110011, opc == 7'b0000011, opc == 7'b0100011, !known};
    ecall = opc == 7'b1110011 && f3 == 0 && exp_inst[31:20] == 12'h000;
    mret = opc == 7'b1110011 && f3 == 0 && exp_inst[31:20] == 12'h302;
    e_sys[3] = opc == 7'b1110011;
    e_sys[2] = opc == 7'b1110011 && f3 == 0 && exp_inst[31:20] == 12'h001;
    e_sys[1] = ecall || mret || e_sys[2];
    e_sys[0] = (e_sys[3] && f3 != 0 && f3 != 4) || ecall || mret;
  end

  task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  a_op1: assert property (@(posedge clk) disable iff (rst) valid_o |-> op1_o == e_op1)
    else report("op1_o", $sampled(op1_o), $sampled(e_op1));
  a_op2: assert property (@(posedge clk) disable iff (rst) valid_o |-> op2_o == e_op2)
    else report("op2_o", $sampled(op2_o), $sampled(e_op2));
  a_imm: assert property (@(posedge clk) disable iff (rst) valid_o |-> imm_o == e_imm)
    else report("imm_o", $sampled(imm_o), $sampled(e_imm));
  a_alu: assert property (@(posedge clk) disable iff (rst) valid_o |-> alu_op_o == e_alu)
    else report("alu_op_o", $sampled(alu_op_o), $sampled(e_alu));
  a_rd: assert property (@(posedge clk) disable iff (rst) valid_o |-> rd_o == e_rd)
    else report("rd_o", $sampled(rd_o), $sampled(e_rd));
  a_fields: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> {rs1_o, rs2_o, opcode_o} == {exp_inst[18:15], exp_inst[23:20], opc})
    else report("rs1_o/rs2_o/opcode_o", $sampled({rs1_o, rs2_o, opcode_o}),
                $sampled({exp_inst[18:15], exp_inst[23:20], opc}));
  a_opj: assert property (@(posedge clk) disable iff (rst) valid_o |-> op_j_o == e_opj)
    else report("op_j_o", $sampled(op_j_o), $sampled(e_opj));
  a_addr: assert property (@(posedge clk) disable iff (rst) valid_o |-> rwaddr_o == e_rwaddr)
    else report("rwaddr_o", $sampled(rwaddr_o), $sampled(e_rwaddr));
  a_ctrl: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> {en_j_o, ren_o, wen_o, illegal_o} == e_ctrl)
    else report("en_j_o/ren_o/wen_o/illegal_o", $sampled({en_j_o, ren_o, wen_o, illegal_o}),
                $sampled(e_ctrl));
  a_sys: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> {system_o, ebreak_o, system_func3_zero_o, csr_wen_o} == e_sys)
    else report("system flags", $sampled({system_o, ebreak_o, system_func3_zero_o, csr_wen_o}),
                $sampled(e_sys));
  a_inst: assert property (@(posedge clk) disable iff (rst) valid_o |-> inst_o == exp_inst)
    else report("inst_o", $sampled(inst_o), $sampled(exp_inst));
  a_pc: assert property (@(posedge clk) disable iff (rst) valid_o |-> pc_o == exp_pc)
    else report("pc_o", $sampled(pc_o), $sampled(exp_pc));
  a_spec: assert property (@(posedge clk) disable iff (rst) valid_o |-> spec_o == exp_spec)
    else report("spec_o", $sampled(spec_o), $sampled(exp_spec));
  a_stall: assert property (@(posedge clk) disable iff (rst) expect_stall |-> !valid_o)
    else report("valid_o", 1, 0);
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |-> !ready_o ##1 (valid_o && $stable(inst_o) && $stable(pc_o)))
    else begin
      errors++;
      $display("held instruction changed or ready_o high under back-pressure at %0t", $time);
    end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_cfg_pkg::reg_cnt; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      if (wb_en_i && wb_rd_i != 0) begin
        shadow[wb_rd_i] <= wb_data_i;
      end
      if (prev_valid_i && ready_o) begin
        accepts <= accepts + 1;
      end
      if (valid_o && next_ready_i) begin
        transfers <= transfers + 1;
        if (rd_o != 0) begin
          pending.push_back(rd_o);
        end
      end
    end
  end

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic send(input core_cfg_pkg::inst_t inst);
    int t;
    logic [31:0] r;
    t = 0;
    r = $random(seed);
    @(negedge clk);
    inst_i = inst;
    spec_i = r[0];
    prev_valid_i = 1'b1;
    #1;
    while (!ready_o) begin
      @(negedge clk);
      #1;
      t++;
      if (t > 50) give_up("ready_o");
    end
    @(posedge clk);
    exp_inst = inst;
    exp_pc = pc_i;
    exp_spec = spec_i;
    @(negedge clk);
    prev_valid_i = 1'b0;
    pc_i = pc_i + 4;
  endtask

  // returns at a falling edge with valid_o high
  task automatic wait_valid(input int limit);
    int t;
    t = 0;
    while (!valid_o) begin
      @(negedge clk);
      t++;
      if (t > limit) give_up("valid_o");
    end
  endtask

  task automatic retire();
    @(negedge clk);
    while (pending.size() > 0) begin
      wb_en_i = 1'b1;
      wb_rd_i = pending.pop_front();
      wb_data_i = $random(seed);
      @(negedge clk);
    end
    wb_en_i = 1'b0;
  endtask

  task automatic run_one(input core_cfg_pkg::inst_t inst);
    send(inst);
    wait_valid(10);
    @(posedge clk);
    retire();
  endtask

  logic [6:0] opcodes [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
                               7'h13, 7'h33, 7'h73, 7'h0b};

  initial begin
    logic [31:0] r;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // fill registers so later reads see nonzero values
    for (int i = 1; i < 16; i++) begin
      run_one({20'h0, 1'b0, i[3:0], 7'h37});
    end
    run_one(32'h00000073);
    run_one(32'h00100073);
    run_one(32'h30200073);
    run_one(32'h0000000b);
    // every funct3 under the system opcode, csr mstatus
    for (int f = 1; f < 8; f++) begin
      run_one({12'h300, 5'd1, f[2:0], 5'd2, 7'h73});
    end
    for (int i = 0; i < 80; i++) begin
      r = $random(seed);
      run_one({r[31:7], opcodes[i % 11]});
    end
    // hazard on x5 until its writeback
    send(32'h000052b7);
    wait_valid(10);
    @(posedge clk);
    send((32'd5 << 15) | (32'd6 << 7) | 32'h33);
    expect_stall = 1'b1;
    repeat (5) @(negedge clk);
    expect_stall = 1'b0;
    retire();
    wait_valid(10);
    @(posedge clk);
    retire();
    // forward x7 from execute
    send(32'h000073b7);
    wait_valid(10);
    @(posedge clk);
    @(negedge clk);
    exu_valid_i = 1'b1;
    exu_rd_i = 4'd7;
    exu_data_i = $random(seed);
    send((32'd7 << 20) | (32'd7 << 15) | (32'd8 << 7) | 32'h33);
    if (!valid_o) begin
      errors++;
      $display("forwarded operand still stalled decode at %0t", $time);
    end
    wait_valid(10);
    @(posedge clk);
    @(negedge clk);
    exu_valid_i = 1'b0;
    retire();
    // a writeback to x0 must leave x0 reading zero
    @(negedge clk);
    wb_en_i = 1'b1;
    wb_rd_i = '0;
    wb_data_i = $random(seed);
    @(negedge clk);
    wb_en_i = 1'b0;
    run_one(32'h000004b3);
    // back-pressure on a held instruction
    send(32'h12310093);
    next_ready_i = 1'b0;
    repeat (4) @(negedge clk);
    next_ready_i = 1'b1;
    @(posedge clk);
    retire();
    repeat (3) @(negedge clk);
    if (accepts != transfers) begin
      errors++;
      $display("accepted and transferred instruction counts differ");
    end
    $display("errors=%0d accepted=%0d transferred=%0d", errors, accepts, transfers);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/system_decoder.sv
design/reg_file.sv
design/busy_table.sv
design/decode_stage.sv
design/decode_top.sv
bench/decode_tb.sv

// File: Bender.yml
package:
  name: rv32e_decode

sources:
  - design/core_cfg_pkg.sv
  - design/rv_isa_pkg.sv
  - design/system_decoder.sv
  - design/reg_file.sv
  - design/busy_table.sv
  - design/decode_stage.sv
  - design/decode_top.sv
  - target: test
    files:
      - bench/decode_tb.sv
